// ==== src/synth_config.svh ====
`ifndef SYNTH_CONFIG_SVH
`define SYNTH_CONFIG_SVH

// UART bit period in clocks
// Kept short so simulation frames stay small
`define SYNTH_CLKS_PER_BIT 8

// Phase accumulator width
`define SYNTH_PHASE_BITS 16

// Frequency code to phase increment shift
// Code 1 gives an increment of 1024, so 64 clocks per cycle
`define SYNTH_PHASE_SHIFT 10

// Noise LFSR start value, must be non-zero
`define SYNTH_LFSR_SEED 16'hACE1

// Bits per I2S channel word
// Two channel words make one ws period
`define SYNTH_I2S_BITS 16

`endif

// ==== src/synth_pkg.sv ====
`include "synth_config.svh"

package synth_pkg;

    // Unsigned 8-bit audio sample, 128 is mid scale
    typedef logic [7:0] sample_t;

    // Frequency code, 0 to 35 from '0'-'9' and 'A'-'Z'
    typedef logic [5:0] freq_code_t;

    // Phase accumulator word
    typedef logic [`SYNTH_PHASE_BITS-1:0] phase_t;

    // Oscillator shape, TRIANGLE is the reset value
    typedef enum logic [1:0] {
        TRIANGLE,
        SAWTOOTH,
        SQUARE,
        SINE
    } wave_e;

endpackage

// ==== src/uart_cmd_pkg.sv ====
package uart_cmd_pkg;

    // One received UART data byte
    typedef logic [7:0] byte_t;

    // Receiver FSM
    typedef enum logic [1:0] {
        IDLE,   // Waiting for a falling edge
        START,  // Checking the start bit at its midpoint
        DATA,   // Eight data bits, LSB first
        STOP    // Stop bit check
    } rx_state_e;

    // Command characters with a fixed meaning
    // All other capitals and the digits are frequency codes
    typedef enum logic [7:0] {
        CMD_NOISE_ON  = 8'h4E, // 'N'
        CMD_NOISE_OFF = 8'h46, // 'F'
        CMD_TRIANGLE  = 8'h54, // 'T'
        CMD_SAWTOOTH  = 8'h53, // 'S'
        CMD_SQUARE    = 8'h51, // 'Q'
        CMD_SINE      = 8'h57  // 'W'
    } cmd_e;

endpackage

// ==== src/uart_rx.sv ====
`timescale 1ns/1ps
`include "synth_config.svh"

module uart_rx (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rx,
    output uart_cmd_pkg::byte_t rx_data,
    output logic                rx_valid
);
    import uart_cmd_pkg::*;

    localparam int CNT_W = $clog2(`SYNTH_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SYNTH_CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] CNT_MID  = CNT_W'(`SYNTH_CLKS_PER_BIT / 2 - 1);

    logic             rx_meta;
    logic             rx_sync;
    logic             rx_last;
    logic             fall;
    logic             bit_tick;
    rx_state_e        state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    byte_t            shreg;

    // Two-flop synchronizer plus edge history, line idles high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    assign fall     = rx_last & ~rx_sync;
    assign bit_tick = (cnt == CNT_LAST); // Midpoint of a data or stop bit

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                IDLE: begin
                    cnt <= '0;
                    if (fall) begin
                        state <= START;
                    end
                end
                START: begin
                    if (cnt == CNT_MID) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? IDLE : DATA; // Glitch, not a start bit
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                DATA: begin
                    cnt <= bit_tick ? '0 : cnt + 1'b1;
                    if (bit_tick) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end
                    end
                end
                STOP: begin
                    cnt <= cnt + 1'b1;
                    if (bit_tick) begin
                        state    <= IDLE;
                        rx_valid <= rx_sync; // Framing error drops the byte
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Data path, LSB arrives first
    always_ff @(posedge clk) begin
        if (state == DATA && bit_tick) begin
            shreg <= {rx_sync, shreg[7:1]};
        end
        if (state == STOP && bit_tick && rx_sync) begin
            rx_data <= shreg; // Held until the next good frame
        end
    end

endmodule

// ==== src/command_decoder.sv ====
`timescale 1ns/1ps

module command_decoder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  uart_cmd_pkg::byte_t   rx_data,
    input  logic                  rx_valid,
    output synth_pkg::wave_e      wave_sel,
    output synth_pkg::freq_code_t freq_code,
    output logic                  noise_en
);
    import synth_pkg::*;
    import uart_cmd_pkg::*;

    localparam byte_t ASCII_0 = 8'h30;
    localparam byte_t ASCII_9 = 8'h39;
    localparam byte_t ASCII_A = 8'h41;
    localparam byte_t ASCII_Z = 8'h5A;

    logic is_digit;
    logic is_upper;

    assign is_digit = (rx_data >= ASCII_0) && (rx_data <= ASCII_9);
    assign is_upper = (rx_data >= ASCII_A) && (rx_data <= ASCII_Z);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wave_sel  <= TRIANGLE;
            freq_code <= '0;
            noise_en  <= 1'b0;
        end else if (rx_valid) begin
            case (rx_data)
                CMD_NOISE_ON:  noise_en <= 1'b1;
                CMD_NOISE_OFF: noise_en <= 1'b0;
                CMD_TRIANGLE:  wave_sel <= TRIANGLE;
                CMD_SAWTOOTH:  wave_sel <= SAWTOOTH;
                CMD_SQUARE:    wave_sel <= SQUARE;
                CMD_SINE:      wave_sel <= SINE;
                default: begin
                    // Opcode letters never reach here, so they are not codes
                    if (is_digit) begin
                        freq_code <= freq_code_t'(rx_data - ASCII_0);
                    end else if (is_upper) begin
                        freq_code <= freq_code_t'(rx_data - ASCII_A + 8'd10); // 'A' is 10
                    end
                end
            endcase
        end
    end

endmodule

// ==== src/wave_synth.sv ====
`timescale 1ns/1ps
`include "synth_config.svh"

module wave_synth (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ena,
    input  synth_pkg::wave_e      wave_sel,
    input  synth_pkg::freq_code_t freq_code,
    input  logic                  noise_en,
    output synth_pkg::sample_t    sample
);
    import synth_pkg::*;

    localparam int PHASE_MSB = `SYNTH_PHASE_BITS - 1;

    // One cycle of sine in 16 steps, mid scale 128
    localparam sample_t SINE_LUT [16] = '{
        8'd128, 8'd176, 8'd218, 8'd246,
        8'd255, 8'd246, 8'd218, 8'd176,
        8'd128, 8'd80,  8'd38,  8'd10,
        8'd0,   8'd10,  8'd38,  8'd80
    };

    phase_t      phase;
    phase_t      phase_inc;
    sample_t     phase_hi;
    sample_t     wave_val;
    logic [15:0] lfsr;
    logic        lfsr_fb;

    assign phase_inc = phase_t'(freq_code) << `SYNTH_PHASE_SHIFT;
    assign phase_hi  = phase[PHASE_MSB -: 8];
    assign lfsr_fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_comb begin
        case (wave_sel)
            TRIANGLE: begin
                // Rising first half, mirrored second half
                if (phase_hi[7]) begin
                    wave_val = ~{phase_hi[6:0], 1'b0};
                end else begin
                    wave_val = {phase_hi[6:0], 1'b0};
                end
            end
            SAWTOOTH: wave_val = phase_hi;
            SQUARE:   wave_val = phase_hi[7] ? 8'hFF : 8'h00;
            SINE:     wave_val = SINE_LUT[phase_hi[7:4]]; // Top four phase bits
            default:  wave_val = phase_hi;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase  <= '0;
            lfsr   <= `SYNTH_LFSR_SEED;
            sample <= '0;
        end else if (ena) begin
            phase  <= phase + phase_inc;           // Wraps once per output cycle
            lfsr   <= {lfsr[14:0], lfsr_fb};       // Runs even while noise is off
            sample <= noise_en ? lfsr[15:8] : wave_val;
        end
    end

endmodule

// ==== src/i2s_tx.sv ====
`timescale 1ns/1ps
`include "synth_config.svh"

module i2s_tx (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ena,
    input  synth_pkg::sample_t sample,
    output logic               sck,
    output logic               ws,
    output logic               sd
);
    import synth_pkg::*;

    localparam int WORD_W = `SYNTH_I2S_BITS;
    localparam int CNT_W  = $clog2(WORD_W);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(WORD_W - 1);

    logic [CNT_W-1:0]  bit_cnt;
    logic [WORD_W-1:0] shreg;
    logic [WORD_W-1:0] new_word;

    // Sample repeated to fill the channel word
    assign new_word = {(WORD_W / $bits(sample_t)){sample}};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sck     <= 1'b0;
            ws      <= 1'b0;
            sd      <= 1'b0;
            bit_cnt <= '0;
            shreg   <= '0; // First word after reset is silent
        end else if (ena) begin
            sck <= ~sck;
            if (sck) begin // sck about to fall
                if (bit_cnt == BIT_LAST) begin
                    // Word boundary, MSB goes out with the ws edge
                    bit_cnt <= '0;
                    ws      <= ~ws;
                    sd      <= new_word[WORD_W-1];
                    shreg   <= new_word << 1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                    sd      <= shreg[WORD_W-1];
                    shreg   <= shreg << 1;
                end
            end
        end
    end

endmodule

// ==== src/synth_top.sv ====
`timescale 1ns/1ps

module synth_top (
    input  logic clk,
    input  logic rst_n,
    input  logic ena,
    input  logic rx,
    output logic sck,
    output logic ws,
    output logic sd
);

    uart_cmd_pkg::byte_t   rx_data;
    logic                  rx_valid;
    synth_pkg::wave_e      wave_sel;
    synth_pkg::freq_code_t freq_code;
    logic                  noise_en;
    synth_pkg::sample_t    sample;

    // UART path runs regardless of ena
    uart_rx u_uart_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    command_decoder u_command_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .wave_sel  (wave_sel),
        .freq_code (freq_code),
        .noise_en  (noise_en)
    );

    wave_synth u_wave_synth (
        .clk       (clk),
        .rst_n     (rst_n),
        .ena       (ena),
        .wave_sel  (wave_sel),
        .freq_code (freq_code),
        .noise_en  (noise_en),
        .sample    (sample)
    );

    i2s_tx u_i2s_tx (
        .clk    (clk),
        .rst_n  (rst_n),
        .ena    (ena),
        .sample (sample),
        .sck    (sck),
        .ws     (ws),
        .sd     (sd)
    );

endmodule

// ==== dv/synth_tb.sv ====
`timescale 1ns/1ps
`include "synth_config.svh"

module synth_tb;
    import synth_pkg::*;
    import uart_cmd_pkg::*;

    localparam int WORD_W        = `SYNTH_I2S_BITS;
    localparam int CAPTURE_WORDS = 16;
    localparam int WAIT_LIMIT    = 200;  // Clocks, well over one I2S word
    localparam int NUM_ROWS      = 17;

    // Reference sine, one cycle in 16 steps
    localparam sample_t SINE_REF [16] = '{
        8'd128, 8'd176, 8'd218, 8'd246, 8'd255, 8'd246, 8'd218, 8'd176,
        8'd128, 8'd80,  8'd38,  8'd10,  8'd0,   8'd10,  8'd38,  8'd80
    };

    typedef enum {FRAME_GOOD, FRAME_BAD_STOP, FRAME_FILLER} frame_e;
    typedef enum {EXP_FIXED, EXP_SINE, EXP_SQUARE, EXP_SWEEP, EXP_NOISE} exp_class_e;

    typedef struct {
        logic       do_reset;   // Reset first, phase back to 0
        frame_e     frame;
        byte_t      cmd;
        exp_class_e exp_class;
        sample_t    value;      // Fixed word byte
        wave_e      wave;       // Shape a sweep should imply
    } row_t;

    logic   clk = 1'b0;
    logic   rst_n;
    logic   ena;
    logic   rx;
    logic   sck;
    logic   ws;
    logic   sd;
    integer seed;
    int     errors;
    int     timeouts;
    row_t   rows [NUM_ROWS];
    logic [WORD_W-1:0] captured [CAPTURE_WORDS];

    synth_top u_synth_top (
        .clk   (clk),
        .rst_n (rst_n),
        .ena   (ena),
        .rx    (rx),
        .sck   (sck),
        .ws    (ws),
        .sd    (sd)
    );

    always #50 clk = ~clk;

    task automatic check_sample(input string name, input sample_t exp, input sample_t got);
        if (exp !== got) begin
            errors++;
            $display("error %s: expected 0x%02h, got 0x%02h", name, exp, got);
        end
    endtask

    task automatic check_wave(input string name, input wave_e exp, input wave_e got);
        if (exp !== got) begin
            errors++;
            $display("error %s: expected 0x%0h, got 0x%0h", name, exp, got);
        end
    endtask

    task automatic check_pin(input string name, input logic exp, input logic got);
        if (exp !== got) begin
            errors++;
            $display("error %s: expected 0x%0h, got 0x%0h", name, exp, got);
        end
    endtask

    function automatic logic in_sine_table(input sample_t v);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < 16; k++) begin
            if (SINE_REF[k] == v) hit = 1'b1;
        end
        return hit;
    endfunction

    // Odd codes advance half a cycle per word, so two values alternate
    function automatic wave_e implied_wave(input sample_t a, input sample_t b);
        if (sample_t'(a - b) == 8'h80) return SAWTOOTH;  // h and h+128
        if (sample_t'(a + b) == 8'hFF) return TRIANGLE;  // Mirror pair
        return SINE;
    endfunction

    task automatic set_row(input int i, input logic rst, input frame_e f, input byte_t c,
                           input exp_class_e e, input sample_t v, input wave_e w);
        rows[i] = '{rst, f, c, e, v, w};
    endtask

    task automatic load_table();
        set_row(0,  1'b1, FRAME_GOOD,     "0", EXP_FIXED,  8'h00, TRIANGLE);
        set_row(1,  1'b0, FRAME_GOOD,     "W", EXP_FIXED,  8'h80, SINE);
        set_row(2,  1'b0, FRAME_GOOD,     "?", EXP_FIXED,  8'h80, SINE);
        set_row(3,  1'b0, FRAME_FILLER,   "a", EXP_FIXED,  8'h80, SINE);
        set_row(4,  1'b0, FRAME_BAD_STOP, "Q", EXP_FIXED,  8'h80, SINE);
        set_row(5,  1'b0, FRAME_GOOD,     "N", EXP_NOISE,  8'h00, SINE);
        set_row(6,  1'b0, FRAME_GOOD,     "F", EXP_FIXED,  8'h80, SINE);
        set_row(7,  1'b0, FRAME_GOOD,     "0", EXP_FIXED,  8'h80, SINE);
        set_row(8,  1'b0, FRAME_GOOD,     "5", EXP_SINE,   8'h00, SINE);
        set_row(9,  1'b0, FRAME_GOOD,     "Q", EXP_SQUARE, 8'h00, SQUARE);
        set_row(10, 1'b0, FRAME_BAD_STOP, "W", EXP_SQUARE, 8'h00, SQUARE);
        set_row(11, 1'b1, FRAME_GOOD,     "0", EXP_FIXED,  8'h00, TRIANGLE);
        set_row(12, 1'b0, FRAME_GOOD,     "T", EXP_FIXED,  8'h00, TRIANGLE);
        set_row(13, 1'b0, FRAME_GOOD,     "S", EXP_FIXED,  8'h00, SAWTOOTH);
        set_row(14, 1'b0, FRAME_GOOD,     "9", EXP_SWEEP,  8'h00, SAWTOOTH);
        set_row(15, 1'b0, FRAME_FILLER,   "a", EXP_SWEEP,  8'h00, SAWTOOTH);
        set_row(16, 1'b0, FRAME_GOOD,     "T", EXP_SWEEP,  8'h00, TRIANGLE);
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // 8N1 frame, LSB first, then two idle bit times
    task automatic send_frame(input byte_t data, input logic stop_level);
        rx = 1'b0;
        repeat (`SYNTH_CLKS_PER_BIT) @(negedge clk);
        for (int b = 0; b < 8; b++) begin
            rx = data[b];
            repeat (`SYNTH_CLKS_PER_BIT) @(negedge clk);
        end
        rx = stop_level;
        repeat (`SYNTH_CLKS_PER_BIT) @(negedge clk);
        rx = 1'b1;
        repeat (2 * `SYNTH_CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic wait_ws_edge();
        logic prev;
        int   n;
        prev = ws;
        n    = 0;
        @(negedge clk);
        while (ws == prev && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (ws == prev) begin
            timeouts++;
            $display("Timed out waiting for a ws edge");
        end
    endtask

    // sck is stable at the falling clk edge, one sample per sck high phase
    task automatic wait_sck_high();
        int n;
        n = 0;
        @(negedge clk);
        while (!sck && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!sck) begin
            timeouts++;
            $display("Timed out waiting for sck to rise");
        end
    endtask

    task automatic capture_word(output logic [WORD_W-1:0] word);
        word = '0;
        if (timeouts != 0) return;
        wait_ws_edge();
        for (int i = 0; i < WORD_W; i++) begin
            if (timeouts == 0) begin
                wait_sck_high();
                word = {word[WORD_W-2:0], sd};  // MSB first
            end
        end
    endtask

    task automatic check_row(input int r);
        sample_t hi;
        sample_t first_val;
        sample_t other_val;
        logic    changed;
        logic    saw_low;
        logic    saw_high;
        logic    outside;
        first_val = captured[0][WORD_W-1 -: 8];
        other_val = first_val;
        changed   = 1'b0;
        saw_low   = 1'b0;
        saw_high  = 1'b0;
        outside   = 1'b0;
        for (int i = 0; i < CAPTURE_WORDS; i++) begin
            hi = captured[i][WORD_W-1 -: 8];
            check_sample("sd word low byte", hi, captured[i][7:0]);  // Doubled sample
            if (hi != first_val && !changed) begin
                changed   = 1'b1;
                other_val = hi;
            end
            if (!in_sine_table(hi)) outside = 1'b1;
            case (rows[r].exp_class)
                EXP_FIXED: check_sample("sd word", rows[r].value, hi);
                EXP_SINE: begin
                    if (!in_sine_table(hi)) begin
                        errors++;
                        $display("error sd word: 0x%02h is not a sine table entry", hi);
                    end
                end
                EXP_SQUARE: begin
                    if (hi == 8'h00) saw_low = 1'b1;
                    else if (hi == 8'hFF) saw_high = 1'b1;
                    else begin
                        errors++;
                        $display("error sd word: 0x%02h is neither 0x00 nor 0xff", hi);
                    end
                end
                default: ;
            endcase
        end
        if (rows[r].exp_class == EXP_SQUARE && !(saw_low && saw_high)) begin
            errors++;
            $display("Row %0d: square wave did not reach both levels", r);
        end
        if (rows[r].exp_class == EXP_SWEEP) begin
            if (!changed) begin
                errors++;
                $display("Row %0d: words never changed while the phase runs", r);
            end else begin
                check_wave("wave_sel", rows[r].wave, implied_wave(first_val, other_val));
            end
        end
        if (rows[r].exp_class == EXP_NOISE && !(changed && outside)) begin
            errors++;
            $display("Row %0d: noise words repeated or stayed within the sine table", r);
        end
    endtask

    task automatic run_row(input int r);
        logic [WORD_W-1:0] skipped;
        byte_t             filler;
        if (rows[r].do_reset) apply_reset();
        case (rows[r].frame)
            FRAME_GOOD:     send_frame(rows[r].cmd, 1'b1);
            FRAME_BAD_STOP: send_frame(rows[r].cmd, 1'b0);
            default: begin
                filler = 8'h61 + byte_t'({$random(seed)} % 26);  // Lower case, never a command
                send_frame(filler, 1'b1);
            end
        endcase
        repeat (2) capture_word(skipped);  // Words that may predate the change
        for (int i = 0; i < CAPTURE_WORDS; i++) begin
            capture_word(captured[i]);
        end
        if (timeouts == 0) check_row(r);
    endtask

    initial begin
        seed     = 32'h8a9e;
        errors   = 0;
        timeouts = 0;
        rst_n    = 1'b0;
        ena      = 1'b0;
        rx       = 1'b1;
        load_table();
        repeat (3) @(negedge clk);
        check_pin("sck", 1'b0, sck);
        check_pin("ws", 1'b0, ws);
        check_pin("sd", 1'b0, sd);
        rst_n = 1'b1;
        repeat (40) begin  // Outputs frozen while ena is low
            @(negedge clk);
            check_pin("sck", 1'b0, sck);
            check_pin("ws", 1'b0, ws);
            check_pin("sd", 1'b0, sd);
        end
        ena = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (timeouts == 0) run_row(r);
        end
        $display("Value errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+src
src/synth_pkg.sv
src/uart_cmd_pkg.sv
src/uart_rx.sv
src/command_decoder.sv
src/wave_synth.sv
src/i2s_tx.sv
src/synth_top.sv
dv/synth_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the synth testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module synth_tb -f src.f -o Vsynth_tb; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vsynth_tb)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx 'TEST OK'; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
